// ==== alu.sv ====
// integer ALU for the stepped unit
// result carries arithmetic, logic and shift outputs
// cond carries the outcome of the four branch compares
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  rv_pkg::alu_op_t         alu_op,
	input  logic [rv_pkg::xlen-1:0] a,
	input  logic [rv_pkg::xlen-1:0] b,
	output logic [rv_pkg::xlen-1:0] result,
	output logic                    cond    // branch compare outcome
);

	logic [4:0] shamt;
	logic       lt_s;  // signed a < b
	logic       lt_u;  // unsigned a < b

	assign shamt = b[4:0];
	assign lt_s  = $signed(a) < $signed(b);
	assign lt_u  = a < b;

	always_comb begin
		result = '0;
		cond   = 1'b0;
		case (alu_op)
			rv_pkg::add_op:  result = a + b;
			rv_pkg::sub_op:  result = a - b;
			rv_pkg::sll_op:  result = a << shamt;
			rv_pkg::slt_op:  result = {{(rv_pkg::xlen-1){1'b0}}, lt_s};
			rv_pkg::sltu_op: result = {{(rv_pkg::xlen-1){1'b0}}, lt_u};
			rv_pkg::xor_op:  result = a ^ b;
			rv_pkg::srl_op:  result = a >> shamt;
			rv_pkg::sra_op:  result = $signed(a) >>> shamt; // sign fill
			rv_pkg::or_op:   result = a | b;
			rv_pkg::and_op:  result = a & b;

			// branches leave result at zero
			rv_pkg::eq_op:                 cond = (a == b);
			rv_pkg::not_eq_op:             cond = (a != b);
			rv_pkg::less_than_op:          cond = lt_s;
			rv_pkg::greater_equal_than_op: cond = !lt_s;
			default: begin
				result = '0;
				cond   = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== apb_step_regs.sv ====
// APB slave register block for the stepped core
// instr write latches the word and fires step the next cycle
// also holds pc load, register select and the status word
// no wait states, pready is tied high
`timescale 1ns/1ps
`default_nettype none

module apb_step_regs (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic [rv_pkg::apb_addr_w-1:0] paddr,
	input  logic                          psel,
	input  logic                          penable,
	input  logic                          pwrite,
	input  logic [rv_pkg::xlen-1:0]       pwdata,
	input  logic [rv_pkg::xlen-1:0]       pc,
	input  logic [rv_pkg::xlen-1:0]       host_rdata,
	input  logic                          illegal,
	input  logic                          branch_taken,
	output logic [rv_pkg::xlen-1:0]       prdata,
	output logic                          pready,
	output logic                          pslverr,
	output logic                          step,
	output logic [rv_pkg::xlen-1:0]       instr,
	output logic                          pc_load,
	output logic [rv_pkg::xlen-1:0]       pc_wdata,
	output logic [4:0]                    host_sel
);

	logic                    access;   // APB access phase
	logic                    addr_err;
	logic                    wr_ok;    // error-free write completing now
	logic [rv_pkg::xlen-1:0] status;
	logic                    illegal_flag;
	logic                    last_branch;
	logic [7:0]              retire_cnt;

	assign access = psel & penable;
	assign status = {16'h0, retire_cnt, 6'h0, last_branch, illegal_flag};

	// offset decode and read mux
	always_comb begin
		addr_err = 1'b0;
		prdata   = '0;
		case (paddr)
			rv_pkg::addr_instr:    addr_err = !pwrite; // write only
			rv_pkg::addr_pc:       prdata   = pc;
			rv_pkg::addr_reg_sel:  prdata   = {{(rv_pkg::xlen-5){1'b0}}, host_sel};
			rv_pkg::addr_reg_data: begin
				prdata   = host_rdata;
				addr_err = pwrite; // read only
			end
			rv_pkg::addr_status:   prdata   = status;
			default:               addr_err = 1'b1; // unmapped
		endcase
	end

	assign pready  = 1'b1;
	assign pslverr = access & addr_err;
	assign wr_ok   = access & pwrite & ~addr_err;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			step     <= 1'b0;
			pc_load  <= 1'b0;
			instr    <= '0;
			host_sel <= '0;
		end else begin
			step    <= wr_ok && paddr == rv_pkg::addr_instr; // single-cycle pulse
			pc_load <= wr_ok && paddr == rv_pkg::addr_pc;
			if (wr_ok && paddr == rv_pkg::addr_instr)
				instr <= pwdata;
			if (wr_ok && paddr == rv_pkg::addr_reg_sel)
				host_sel <= pwdata[4:0];
		end
	end

	// pc value rides along with the pc_load pulse
	always_ff @(posedge clk) begin
		if (wr_ok && paddr == rv_pkg::addr_pc)
			pc_wdata <= pwdata;
	end

	// status: sticky illegal, last branch, retire counter
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			illegal_flag <= 1'b0;
			last_branch  <= 1'b0;
			retire_cnt   <= '0;
		end else begin
			if (wr_ok && paddr == rv_pkg::addr_status && pwdata[0])
				illegal_flag <= 1'b0; // write 1 to clear
			if (step) begin
				if (illegal)
					illegal_flag <= 1'b1;
				last_branch <= branch_taken;
				retire_cnt  <= retire_cnt + 8'd1; // wraps at 256
			end
		end
	end

endmodule

`default_nettype wire

// ==== control_unit.sv ====
// instruction decoder for the stepped RV32I subset
// purely combinational: opcode/func3/func7 in, datapath controls out
// anything outside the subset raises illegal and suppresses all writes
`timescale 1ns/1ps
`default_nettype none

module control_unit (
	input  rv_pkg::opcode_t  opcode,
	input  logic [2:0]       func3,
	input  logic [6:0]       func7,
	output rv_pkg::alu_op_t  alu_op,
	output rv_pkg::alu_src_t alu_src,
	output rv_pkg::mem_op_t  memory_op,
	output logic             reg_wb,       // write rd on step
	output logic             is_branch_op,
	output logic             illegal
);

	always_comb begin
		// defaults first so nothing latches
		alu_op       = rv_pkg::add_op;
		alu_src      = rv_pkg::src_reg2;
		memory_op    = rv_pkg::no_mem_op;
		reg_wb       = 1'b0;
		is_branch_op = 1'b0;
		illegal      = 1'b0;

		case (opcode)
			rv_pkg::r_type: begin
				reg_wb = 1'b1;
				case (func3)
					3'b000: alu_op = func7[5] ? rv_pkg::sub_op : rv_pkg::add_op;
					3'b001: alu_op = rv_pkg::sll_op;
					3'b010: alu_op = rv_pkg::slt_op;
					3'b011: alu_op = rv_pkg::sltu_op;
					3'b100: alu_op = rv_pkg::xor_op;
					3'b101: alu_op = func7[5] ? rv_pkg::sra_op : rv_pkg::srl_op;
					3'b110: alu_op = rv_pkg::or_op;
					default: alu_op = rv_pkg::and_op; // 3'b111
				endcase
				// only 0000000, or 0100000 for sub/sra, is a valid func7
				if (func7 != 7'h00 &&
				    !(func7 == 7'h20 && (func3 == 3'b000 || func3 == 3'b101)))
					illegal = 1'b1;
			end

			rv_pkg::i_type_arth: begin
				alu_src = rv_pkg::immediate;
				reg_wb  = 1'b1;
				// func7 only meaningful for shifts right, core passes 0 otherwise
				case (func3)
					3'b000: alu_op = rv_pkg::add_op; // addi, negative imm still adds
					3'b001: alu_op = rv_pkg::sll_op;
					3'b010: alu_op = rv_pkg::slt_op;
					3'b011: alu_op = rv_pkg::sltu_op;
					3'b100: alu_op = rv_pkg::xor_op;
					3'b101: begin
						alu_op = func7[5] ? rv_pkg::sra_op : rv_pkg::srl_op;
						if (func7 != 7'h00 && func7 != 7'h20)
							illegal = 1'b1;
					end
					3'b110: alu_op = rv_pkg::or_op;
					default: alu_op = rv_pkg::and_op;
				endcase
			end

			rv_pkg::i_type_load: begin
				alu_src   = rv_pkg::immediate; // rs1 + offset
				memory_op = rv_pkg::mem_read;
				reg_wb    = 1'b1;              // func3 ignored, always a word
			end

			rv_pkg::s_type: begin
				alu_src   = rv_pkg::immediate;
				memory_op = rv_pkg::mem_write;
			end

			rv_pkg::sb_type: begin
				is_branch_op = 1'b1;
				case (func3)
					3'b000: alu_op = rv_pkg::eq_op;
					3'b001: alu_op = rv_pkg::not_eq_op;
					3'b100: alu_op = rv_pkg::less_than_op;
					3'b101: alu_op = rv_pkg::greater_equal_than_op;
					default: illegal = 1'b1; // bltu/bgeu not in the subset
				endcase
			end

			default: illegal = 1'b1; // unknown opcode
		endcase

		// illegal word: no writes, no branch, pc just steps by 4
		if (illegal) begin
			reg_wb       = 1'b0;
			memory_op    = rv_pkg::no_mem_op;
			is_branch_op = 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== data_mem.sv ====
// small word-addressed data memory for lw/sw
// write on the clock edge, read is combinational
// contents cleared on reset so loads from untouched words give zero
`timescale 1ns/1ps
`default_nettype none

module data_mem (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    we,
	input  logic [3:0]              addr,   // word index
	input  logic [rv_pkg::xlen-1:0] wdata,
	output logic [rv_pkg::xlen-1:0] rdata
);

	logic [rv_pkg::xlen-1:0] mem [rv_pkg::dmem_words];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < rv_pkg::dmem_words; i++)
				mem[i] <= '0;
		end else if (we) begin
			mem[addr] <= wdata;
		end
	end

	assign rdata = mem[addr]; // async read

endmodule

`default_nettype wire

// ==== exec_core.sv ====
// single-step execution core
// decodes the held instruction word, reads operands, and on a step pulse
// commits the register/memory write and advances pc
// pc_load from the host overrides a step in the same cycle
`timescale 1ns/1ps
`default_nettype none

module exec_core (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    step,        // one-cycle execute pulse
	input  logic [rv_pkg::xlen-1:0] instr,
	input  logic                    pc_load,
	input  logic [rv_pkg::xlen-1:0] pc_wdata,
	input  logic [4:0]              host_sel,
	output logic [rv_pkg::xlen-1:0] pc,
	output logic [rv_pkg::xlen-1:0] host_rdata,
	output logic                    illegal,     // valid in the step cycle
	output logic                    branch_taken // valid in the step cycle
);

	rv_pkg::opcode_t         opcode;
	logic [2:0]              func3;
	logic [6:0]              func7;
	rv_pkg::alu_op_t         alu_op;
	rv_pkg::alu_src_t        alu_src;
	rv_pkg::mem_op_t         memory_op;
	logic                    reg_wb;
	logic                    is_branch_op;
	logic                    cond;
	logic [rv_pkg::xlen-1:0] imm;
	logic [rv_pkg::xlen-1:0] rdata1, rdata2;
	logic [rv_pkg::xlen-1:0] alu_b;
	logic [rv_pkg::xlen-1:0] alu_result;
	logic [rv_pkg::xlen-1:0] mem_rdata;
	logic [rv_pkg::xlen-1:0] wb_data;

	assign opcode = rv_pkg::opcode_t'(instr[6:0]);
	assign func3  = instr[14:12];
	// I-type: upper bits are immediate, only srli/srai care about them
	assign func7  = (opcode == rv_pkg::i_type_arth && func3 != 3'b101) ? 7'd0 : instr[31:25];

	// immediate by format, I is the fallback
	always_comb begin
		case (opcode)
			rv_pkg::s_type:  imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			rv_pkg::sb_type: imm = {{19{instr[31]}}, instr[31], instr[7],
			                        instr[30:25], instr[11:8], 1'b0};
			default:         imm = {{20{instr[31]}}, instr[31:20]};
		endcase
	end

	control_unit i_control_unit (
		.opcode       (opcode),
		.func3        (func3),
		.func7        (func7),
		.alu_op       (alu_op),
		.alu_src      (alu_src),
		.memory_op    (memory_op),
		.reg_wb       (reg_wb),
		.is_branch_op (is_branch_op),
		.illegal      (illegal)
	);

	assign alu_b = (alu_src == rv_pkg::immediate) ? imm : rdata2;

	alu i_alu (
		.alu_op (alu_op),
		.a      (rdata1),
		.b      (alu_b),
		.result (alu_result),
		.cond   (cond)
	);

	assign wb_data = (memory_op == rv_pkg::mem_read) ? mem_rdata : alu_result;

	reg_file i_reg_file (
		.clk        (clk),
		.rst_n      (rst_n),
		.rs1        (instr[19:15]),
		.rs2        (instr[24:20]),
		.host_sel   (host_sel),
		.we         (step & reg_wb),
		.rd         (instr[11:7]),
		.wdata      (wb_data),
		.rdata1     (rdata1),
		.rdata2     (rdata2),
		.host_rdata (host_rdata)
	);

	data_mem i_data_mem (
		.clk   (clk),
		.rst_n (rst_n),
		.we    (step && memory_op == rv_pkg::mem_write),
		.addr  (alu_result[5:2]), // word index, low bits dropped
		.wdata (rdata2),
		.rdata (mem_rdata)
	);

	assign branch_taken = is_branch_op & cond; // decoder clears branch on illegal

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			pc <= '0;
		else if (pc_load)
			pc <= pc_wdata;
		else if (step)
			pc <= branch_taken ? pc + imm : pc + 32'd4;
	end

endmodule

`default_nettype wire

// ==== files.f ====
rv_pkg.sv
control_unit.sv
alu.sv
reg_file.sv
data_mem.sv
exec_core.sv
apb_step_regs.sv
rv_step_top.sv
rv_step_properties.sv
tb_rv_step.sv

// ==== reg_file.sv ====
// 32 x 32 integer register file, x0 reads as zero
// two async read ports for execution, one for host readback
// single write port, written on the clock edge when we is high
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic [4:0]              rs1,
	input  logic [4:0]              rs2,
	input  logic [4:0]              host_sel,
	input  logic                    we,
	input  logic [4:0]              rd,
	input  logic [rv_pkg::xlen-1:0] wdata,
	output logic [rv_pkg::xlen-1:0] rdata1,
	output logic [rv_pkg::xlen-1:0] rdata2,
	output logic [rv_pkg::xlen-1:0] host_rdata
);

	logic [rv_pkg::xlen-1:0] regs [rv_pkg::reg_count];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < rv_pkg::reg_count; i++)
				regs[i] <= '0;
		end else if (we && rd != 5'd0) begin // x0 never written
			regs[rd] <= wdata;
		end
	end

	// x0 stays zero since it is cleared on reset and never written
	assign rdata1     = regs[rs1];
	assign rdata2     = regs[rs2];
	assign host_rdata = regs[host_sel];

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and grep the log for the pass line
rm -f sim.log
verilator --binary --timing --assert --top-module tb_rv_step -f files.f -o tb_rv_step \
	&& ./obj_dir/tb_rv_step > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "TEST PASSED" sim.log && echo "run passed" || { echo "run failed"; exit 1; }

// ==== rv_pkg.sv ====
// shared sizes, APB register map and decode enums for the stepped RV32I unit
// every other file refers to these by rv_pkg:: scoped names
`default_nettype none

package rv_pkg;

	localparam int xlen       = 32; // data path width
	localparam int reg_count  = 32; // integer register file depth
	localparam int dmem_words = 16; // data memory depth in words
	localparam int apb_addr_w = 5;

	// APB register offsets
	localparam logic [apb_addr_w-1:0] addr_instr    = 5'h00; // write only, issues a step
	localparam logic [apb_addr_w-1:0] addr_pc       = 5'h04;
	localparam logic [apb_addr_w-1:0] addr_reg_sel  = 5'h08; // 5-bit register select
	localparam logic [apb_addr_w-1:0] addr_reg_data = 5'h0C; // read only
	localparam logic [apb_addr_w-1:0] addr_status   = 5'h10;

	// major opcodes handled by the decoder
	typedef enum logic [6:0] {
		r_type      = 7'b0110011,
		i_type_load = 7'b0000011,
		i_type_arth = 7'b0010011,
		s_type      = 7'b0100011,
		sb_type     = 7'b1100011
	} opcode_t;

	typedef enum logic [3:0] {
		add_op,
		sub_op,
		sll_op,
		slt_op,
		sltu_op,
		xor_op,
		srl_op,
		sra_op,
		or_op,
		and_op,
		// branch compares, result goes to cond only
		eq_op,
		not_eq_op,
		less_than_op,
		greater_equal_than_op
	} alu_op_t;

	typedef enum logic {
		src_reg2,  // second operand from rs2
		immediate  // second operand from the extracted immediate
	} alu_src_t;

	typedef enum logic [1:0] {
		no_mem_op,
		mem_read,
		mem_write
	} mem_op_t;

endpackage

`default_nettype wire

// ==== rv_step_properties.sv ====
// concurrent checks on the APB slave and the register file
// attached to rv_step_top with bind
`timescale 1ns/1ps
`default_nettype none

module rv_step_properties (
	input logic                    clk,
	input logic                    rst_n,
	input logic                    psel,
	input logic                    penable,
	input logic                    pslverr,
	input logic                    step,
	input logic [4:0]              host_sel,
	input logic [rv_pkg::xlen-1:0] host_rdata
);

	// error response only in the access phase
	slverr_in_access: assert property (@(posedge clk) disable iff (!rst_n)
		pslverr |-> (psel && penable))
		else $error("pslverr raised outside an APB access phase");

	x0_reads_zero: assert property (@(posedge clk) disable iff (!rst_n)
		(host_sel == 5'd0) |-> (host_rdata == '0))
		else $error("host read of x0 returned nonzero");

	step_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		step |=> !step)
		else $error("step held high for more than one cycle");

endmodule

bind rv_step_top rv_step_properties i_rv_step_properties (
	.clk        (clk),
	.rst_n      (rst_n),
	.psel       (psel),
	.penable    (penable),
	.pslverr    (pslverr),
	.step       (step),
	.host_sel   (host_sel),
	.host_rdata (host_rdata)
);

`default_nettype wire

// ==== rv_step_top.sv ====
// top of the host-stepped RV32I unit
// APB register block in front, execution core behind it
`timescale 1ns/1ps
`default_nettype none

module rv_step_top (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic [rv_pkg::apb_addr_w-1:0] paddr,
	input  logic                          psel,
	input  logic                          penable,
	input  logic                          pwrite,
	input  logic [rv_pkg::xlen-1:0]       pwdata,
	output logic [rv_pkg::xlen-1:0]       prdata,
	output logic                          pready,
	output logic                          pslverr
);

	logic                    step;
	logic [rv_pkg::xlen-1:0] instr;
	logic                    pc_load;
	logic [rv_pkg::xlen-1:0] pc_wdata;
	logic [4:0]              host_sel;
	logic [rv_pkg::xlen-1:0] pc;
	logic [rv_pkg::xlen-1:0] host_rdata;
	logic                    illegal;
	logic                    branch_taken;

	apb_step_regs i_apb_step_regs (
		.clk          (clk),
		.rst_n        (rst_n),
		.paddr        (paddr),
		.psel         (psel),
		.penable      (penable),
		.pwrite       (pwrite),
		.pwdata       (pwdata),
		.pc           (pc),
		.host_rdata   (host_rdata),
		.illegal      (illegal),
		.branch_taken (branch_taken),
		.prdata       (prdata),
		.pready       (pready),
		.pslverr      (pslverr),
		.step         (step),
		.instr        (instr),
		.pc_load      (pc_load),
		.pc_wdata     (pc_wdata),
		.host_sel     (host_sel)
	);

	exec_core i_exec_core (
		.clk          (clk),
		.rst_n        (rst_n),
		.step         (step),
		.instr        (instr),
		.pc_load      (pc_load),
		.pc_wdata     (pc_wdata),
		.host_sel     (host_sel),
		.pc           (pc),
		.host_rdata   (host_rdata),
		.illegal      (illegal),
		.branch_taken (branch_taken)
	);

endmodule

`default_nettype wire

// ==== tb_rv_step.sv ====
// directed testbench for the host-stepped RV32I unit
// drives the APB register block, steps instructions one at a time and
// compares pc, registers and status with a reference model of the rules
`timescale 1ns/1ps
`default_nettype none

module tb_rv_step;

	logic        clk;
	logic        rst_n;
	logic [4:0]  paddr;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;

	// reference model state
	logic [31:0] m_regs [32];
	logic [31:0] m_mem [16];
	logic [31:0] m_pc;
	logic        m_illegal; // sticky
	logic        m_branch;  // last step taken branch
	logic [7:0]  m_retire;
	int          seed;

	rv_step_top i_rv_step_top (
		.clk     (clk),
		.rst_n   (rst_n),
		.paddr   (paddr),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr)
	);

	always #2 clk = ~clk; // 4 ns period

	task abort_run(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("mismatch %s: got 0x%08h expected 0x%08h", name, got, exp);
			abort_run("value check failed");
		end
	endtask

	function automatic logic [31:0] rnd();
		return $random(seed);
	endfunction

	// instruction word builders
	function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, rv_pkg::r_type};
	endfunction

	function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] s_word(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_pkg::s_type};
	endfunction

	function automatic logic [31:0] b_word(input logic [12:0] off, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_pkg::sb_type};
	endfunction

	// RV32I result for one func3 where alt picks sub/sra
	function automatic logic [31:0] calc(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		logic        [4:0]  sh;
		logic signed [31:0] sa;
		sh = b[4:0];
		sa = a;
		case (f3)
			3'b000: return alt ? a - b : a + b;
			3'b001: return a << sh;
			3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'b011: return (a < b) ? 32'd1 : 32'd0;
			3'b100: return a ^ b;
			3'b101: begin
				if (alt)
					return sa >>> sh; // sign fill
				return a >> sh;
			end
			3'b110: return a | b;
			default: return a & b;
		endcase
	endfunction

	// apply one instruction to the model
	task automatic predict_step(input logic [31:0] ins);
		logic [6:0]  op;
		logic [4:0]  rd;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm_i;
		logic [31:0] imm_s;
		logic [31:0] imm_b;
		logic [31:0] addr;
		logic [31:0] res;
		logic        wb;
		logic        taken;
		logic        bad;
		op    = ins[6:0];
		rd    = ins[11:7];
		a     = m_regs[ins[19:15]];
		b     = m_regs[ins[24:20]];
		imm_i = {{20{ins[31]}}, ins[31:20]};
		imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
		imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
		wb    = 1'b0;
		taken = 1'b0;
		bad   = 1'b0;
		res   = '0;
		case (op)
			rv_pkg::r_type: begin
				res = calc(ins[14:12], ins[30], a, b);
				wb  = 1'b1;
			end
			rv_pkg::i_type_arth: begin
				// bit 30 only matters for shifts right
				res = calc(ins[14:12], ins[30] && ins[14:12] == 3'b101, a, imm_i);
				wb  = 1'b1;
			end
			rv_pkg::i_type_load: begin
				addr = a + imm_i;
				res  = m_mem[addr[5:2]];
				wb   = 1'b1;
			end
			rv_pkg::s_type: begin
				addr = a + imm_s;
				m_mem[addr[5:2]] = b;
			end
			rv_pkg::sb_type: begin
				case (ins[14:12])
					3'b000: taken = (a == b);
					3'b001: taken = (a != b);
					3'b100: taken = $signed(a) < $signed(b);
					3'b101: taken = $signed(a) >= $signed(b);
					default: bad = 1'b1;
				endcase
			end
			default: bad = 1'b1;
		endcase
		if (wb && rd != 5'd0)
			m_regs[rd] = res;
		m_pc     = taken ? m_pc + imm_b : m_pc + 32'd4;
		m_branch = taken;
		m_retire = m_retire + 8'd1;
		if (bad)
			m_illegal = 1'b1;
	endtask

	task apb_write(input logic [4:0] addr, input logic [31:0] data, output logic err);
		int cnt;
		@(posedge clk); // setup phase
		paddr   <= addr;
		pwrite  <= 1'b1;
		pwdata  <= data;
		psel    <= 1'b1;
		penable <= 1'b0;
		@(posedge clk);
		penable <= 1'b1;
		cnt = 0;
		@(negedge clk);
		while (pready !== 1'b1) begin
			cnt++;
			if (cnt > 16)
				abort_run("APB write got no pready");
			@(negedge clk);
		end
		err = pslverr;
		@(posedge clk); // completes here
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task apb_read(input logic [4:0] addr, output logic [31:0] data, output logic err);
		int cnt;
		@(posedge clk);
		paddr   <= addr;
		pwrite  <= 1'b0;
		psel    <= 1'b1;
		penable <= 1'b0;
		@(posedge clk);
		penable <= 1'b1;
		cnt = 0;
		@(negedge clk);
		while (pready !== 1'b1) begin
			cnt++;
			if (cnt > 16)
				abort_run("APB read got no pready");
			@(negedge clk);
		end
		data = prdata; // sampled mid-cycle while stable
		err  = pslverr;
		@(posedge clk);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task step_instr(input logic [31:0] ins);
		logic err;
		apb_write(rv_pkg::addr_instr, ins, err);
		check("pslverr", 32'(err), 32'd0);
		predict_step(ins);
	endtask

	task reg_readback(input logic [4:0] r);
		logic        err;
		logic [31:0] d;
		apb_write(rv_pkg::addr_reg_sel, 32'(r), err);
		apb_read(rv_pkg::addr_reg_data, d, err);
		check($sformatf("reg_data x%0d", r), d, m_regs[r]);
	endtask

	task pc_readback();
		logic        err;
		logic [31:0] d;
		apb_read(rv_pkg::addr_pc, d, err);
		check("pc", d, m_pc);
	endtask

	task status_readback();
		logic        err;
		logic [31:0] d;
		apb_read(rv_pkg::addr_status, d, err);
		check("status", d, {16'h0, m_retire, 6'h0, m_branch, m_illegal});
	endtask

	task reg_access();
		logic        err;
		logic [31:0] d;
		apb_write(rv_pkg::addr_pc, 32'h0000_0100, err);
		check("pslverr", 32'(err), 32'd0);
		m_pc = 32'h0000_0100;
		pc_readback();
		apb_write(rv_pkg::addr_reg_sel, 32'h0000_0007, err);
		apb_read(rv_pkg::addr_reg_sel, d, err);
		check("reg_sel", d, 32'd7);
		// error responses
		apb_read(5'h14, d, err);
		check("pslverr", 32'(err), 32'd1);
		apb_write(5'h1C, rnd(), err);
		check("pslverr", 32'(err), 32'd1);
		apb_read(rv_pkg::addr_instr, d, err);
		check("pslverr", 32'(err), 32'd1);
		apb_write(rv_pkg::addr_reg_data, rnd(), err);
		check("pslverr", 32'(err), 32'd1);
		// nothing moved
		pc_readback();
		apb_read(rv_pkg::addr_reg_sel, d, err);
		check("reg_sel", d, 32'd7);
		status_readback();
	endtask

	task r_type_ops();
		logic [11:0] imm;
		for (int i = 1; i <= 6; i++) begin
			imm = 12'(rnd());
			if (i == 2)
				imm[11] = 1'b0; // x2 positive
			if (i == 6)
				imm[11] = 1'b1; // x6 negative so slt/sltu and sra/srl differ
			step_instr(i_word(imm, 5'd0, 3'b000, 5'(i), rv_pkg::i_type_arth));
		end
		step_instr(r_word(7'h00, 5'd2, 5'd1, 3'b000, 5'd10)); // add
		step_instr(r_word(7'h20, 5'd4, 5'd3, 3'b000, 5'd11)); // sub
		step_instr(r_word(7'h00, 5'd5, 5'd1, 3'b001, 5'd12)); // sll
		step_instr(r_word(7'h00, 5'd6, 5'd2, 3'b010, 5'd13)); // slt
		step_instr(r_word(7'h00, 5'd6, 5'd2, 3'b011, 5'd14)); // sltu
		step_instr(r_word(7'h00, 5'd1, 5'd4, 3'b100, 5'd15)); // xor
		step_instr(r_word(7'h00, 5'd3, 5'd6, 3'b101, 5'd16)); // srl
		step_instr(r_word(7'h20, 5'd3, 5'd6, 3'b101, 5'd17)); // sra
		step_instr(r_word(7'h00, 5'd5, 5'd2, 3'b110, 5'd18)); // or
		step_instr(r_word(7'h00, 5'd3, 5'd1, 3'b111, 5'd19)); // and
		step_instr(r_word(7'h00, 5'd2, 5'd1, 3'b000, 5'd0));  // add into x0
		for (int r = 0; r <= 19; r++)
			reg_readback(5'(r));
	endtask

	task i_type_ops();
		// x7 forced negative so srai and srli differ
		step_instr(i_word({1'b1, 11'(rnd())}, 5'd0, 3'b000, 5'd7, rv_pkg::i_type_arth));
		step_instr(i_word({1'b1, 11'(rnd())}, 5'd1, 3'b000, 5'd20, rv_pkg::i_type_arth));
		step_instr(i_word(12'(rnd()), 5'd2, 3'b010, 5'd21, rv_pkg::i_type_arth)); // slti
		step_instr(i_word(12'(rnd()), 5'd3, 3'b100, 5'd22, rv_pkg::i_type_arth)); // xori
		step_instr(i_word({7'h00, 5'(rnd())}, 5'd4, 3'b001, 5'd23, rv_pkg::i_type_arth));
		step_instr(i_word({7'h00, 5'(rnd())}, 5'd7, 3'b101, 5'd24, rv_pkg::i_type_arth));
		step_instr(i_word({7'h20, 5'(rnd())}, 5'd7, 3'b101, 5'd25, rv_pkg::i_type_arth));
		reg_readback(5'd7);
		for (int r = 20; r <= 25; r++)
			reg_readback(5'(r));
	endtask

	task load_store();
		step_instr(s_word(12'd8, 5'd3, 5'd0)); // sw x3, 8(x0)
		pc_readback();
		step_instr(s_word(12'd60, 5'd7, 5'd0)); // last word
		pc_readback();
		step_instr(i_word(12'd8, 5'd0, 3'b010, 5'd29, rv_pkg::i_type_load));
		pc_readback();
		step_instr(i_word(12'd60, 5'd0, 3'b010, 5'd30, rv_pkg::i_type_load));
		pc_readback();
		reg_readback(5'd29);
		reg_readback(5'd30);
	endtask

	task branch_case(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2);
		logic [12:0] off;
		off = {12'(rnd()), 1'b0}; // even offset
		step_instr(b_word(off, rs2, rs1, f3));
		pc_readback();
		status_readback();
	endtask

	task branches();
		step_instr(i_word(12'hFFD, 5'd0, 3'b000, 5'd27, rv_pkg::i_type_arth)); // x27 = -3
		step_instr(i_word(12'd7, 5'd0, 3'b000, 5'd28, rv_pkg::i_type_arth));   // x28 = 7
		branch_case(3'b000, 5'd27, 5'd27); // beq taken
		branch_case(3'b000, 5'd27, 5'd28);
		branch_case(3'b001, 5'd27, 5'd28); // bne taken
		branch_case(3'b001, 5'd28, 5'd28);
		branch_case(3'b100, 5'd27, 5'd28); // blt taken as a signed compare
		branch_case(3'b100, 5'd28, 5'd27);
		branch_case(3'b101, 5'd28, 5'd27); // bge taken
		branch_case(3'b101, 5'd27, 5'd28);
	endtask

	task illegal_op();
		logic err;
		// x31 nonzero so a stray write from the illegal word would show
		step_instr(i_word(12'h5A5, 5'd0, 3'b000, 5'd31, rv_pkg::i_type_arth));
		step_instr(32'hFFFF_FFFF); // unknown opcode with rd x31
		status_readback();
		for (int r = 0; r < 32; r++)
			reg_readback(5'(r));
		step_instr(i_word(12'd1, 5'd1, 3'b000, 5'd1, rv_pkg::i_type_arth));
		status_readback(); // flag still set
		pc_readback();
		apb_write(rv_pkg::addr_status, 32'd1, err); // write 1 to clear
		check("pslverr", 32'(err), 32'd0);
		m_illegal = 1'b0;
		status_readback();
	endtask

	initial begin
		clk     = 1'b0;
		rst_n   = 1'b0;
		paddr   = '0;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		pwdata  = '0;
		seed    = 32'hb529;
		for (int i = 0; i < 32; i++)
			m_regs[i] = '0;
		for (int i = 0; i < 16; i++)
			m_mem[i] = '0;
		m_pc      = '0;
		m_illegal = 1'b0;
		m_branch  = 1'b0;
		m_retire  = '0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;

		pc_readback(); // reset values
		status_readback();
		reg_access();
		r_type_ops();
		i_type_ops();
		load_store();
		branches();
		illegal_op();

		$display("TEST PASSED");
		$finish;
	end

endmodule

`default_nettype wire
